// ==== systolic_array.f ====
hdl/systolic_pkg.sv
hdl/operand_skew.sv
hdl/mac_pe.sv
hdl/result_deskew.sv
hdl/systolic_array.sv
+incdir+verif
verif/systolic_array_tb.sv

// ==== verif/systolic_tests.svh ====
// random operands for steps 0..len-1
task automatic fill_random(input int len);
    logic [31:0] word;
    for (int k = 0; k < len; k++) begin
        for (int r = 0; r < ROWS; r++) begin
            word = lcg_next();
            a_mat[r][k] = word[23:16];
        end
        for (int c = 0; c < COLS; c++) begin
            word = lcg_next();
            b_mat[k][c] = word[23:16];
        end
    end
endtask

task automatic build_expected(input int len);
    for (int r = 0; r < ROWS; r++) begin
        for (int c = 0; c < COLS; c++) begin
            exp_mat[r][c] = ref_dot(r, c, len);
        end
    end
endtask

// start pulse, then len aligned steps with up to max_gap idle cycles between them
task automatic drive_job(input int len, input int max_gap);
    int          gap;
    logic [31:0] word;
    @(posedge clk);
    #2;
    start   = 1'b1;
    job_len = count_t'(len);
    @(posedge clk);
    #2;
    start = 1'b0;
    for (int k = 0; k < len; k++) begin
        step_valid = 1'b1;
        for (int r = 0; r < ROWS; r++) begin
            feat[r] = a_mat[r][k];
        end
        for (int c = 0; c < COLS; c++) begin
            wgt[c] = b_mat[k][c];
        end
        @(posedge clk);
        #2;
        step_valid = 1'b0;
        gap = 0;
        if (max_gap > 0 && k < len - 1) begin
            word = lcg_next();
            gap  = int'(word[17:16]) % (max_gap + 1);
        end
        repeat (gap) begin
            @(posedge clk);
            #2;
        end
    end
endtask

// one pulse per row, in row order
task automatic collect_rows();
    int waited;
    bit seen;
    for (int r = 0; r < ROWS; r++) begin
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < PULSE_WAIT) begin
            @(negedge clk);
            waited++;
            if (res_valid === 1'b1) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("result pulse for row %0d did not arrive within %0d cycles", r, PULSE_WAIT);
            err_count++;
            return;
        end
        for (int c = 0; c < COLS; c++) begin
            check_acc($sformatf("res_o[%0d] row %0d", c, r), exp_mat[r][c], res[c]);
        end
    end
endtask

task automatic expect_no_pulse(input int cycles);
    repeat (cycles) begin
        @(negedge clk);
        check_valid("res_valid_o", 1'b0, res_valid);
    end
endtask

task automatic quiet_after_reset();
    int errs_before;
    errs_before = err_count;
    rst = 1'b1;
    for (int i = 0; i < RESET_CYCLES - 1; i++) begin
        @(posedge clk);
        @(negedge clk);
        check_valid("res_valid_o", 1'b0, res_valid);
    end
    @(posedge clk);
    #2;
    rst = 1'b0;
    expect_no_pulse(20);
    report_test("reset_quiet", errs_before);
endtask

task automatic identity_weights();
    int errs_before;
    errs_before = err_count;
    fill_random(4);
    for (int k = 0; k < 4; k++) begin
        for (int c = 0; c < COLS; c++) begin
            b_mat[k][c] = (k == c) ? wgt_t'(1) : wgt_t'(0);
        end
    end
    for (int r = 0; r < ROWS; r++) begin
        for (int c = 0; c < COLS; c++) begin
            exp_mat[r][c] = acc_t'(int'(a_mat[r][c]));
        end
    end
    drive_job(4, 0);
    collect_rows();
    expect_no_pulse(20);   // no fifth row
    report_test("identity_weights", errs_before);
endtask

task automatic signed_extremes();
    int errs_before;
    errs_before = err_count;
    for (int k = 0; k < MAX_K; k++) begin
        for (int r = 0; r < ROWS; r++) begin
            a_mat[r][k] = 8'd255;
        end
        for (int c = 0; c < COLS; c++) begin
            b_mat[k][c] = -8'sd128;
        end
    end
    for (int r = 0; r < ROWS; r++) begin
        for (int c = 0; c < COLS; c++) begin
            exp_mat[r][c] = -32'sd8323200;   // 255 * 255 * -128
        end
    end
    drive_job(MAX_K, 0);
    collect_rows();
    expect_no_pulse(10);
    report_test("signed_extremes", errs_before);
endtask

task automatic gapped_random_job();
    int errs_before;
    errs_before = err_count;
    fill_random(16);
    build_expected(16);
    drive_job(16, 3);
    collect_rows();
    expect_no_pulse(10);
    report_test("gapped_random", errs_before);
endtask

task automatic back_to_back_jobs();
    int errs_before;
    errs_before = err_count;
    for (int job = 0; job < 2; job++) begin
        fill_random(16);
        build_expected(16);
        drive_job(16, 1);   // second start follows the last pulse directly
        collect_rows();
    end
    expect_no_pulse(10);
    report_test("back_to_back", errs_before);
endtask

task automatic single_step_job();
    int errs_before;
    errs_before = err_count;
    fill_random(1);
    for (int r = 0; r < ROWS; r++) begin
        for (int c = 0; c < COLS; c++) begin
            exp_mat[r][c] = acc_t'(int'(a_mat[r][0]) * int'(b_mat[0][c]));
        end
    end
    drive_job(1, 0);
    collect_rows();
    expect_no_pulse(10);
    report_test("single_step", errs_before);
endtask

// ==== verif/systolic_array_tb.sv ====
`timescale 1ns/10ps

module systolic_array_tb;

    import systolic_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int MAX_K        = 255;
    localparam int PULSE_WAIT   = 32;     // a row pulse is due within ~12 cycles of the last step
    // the 255-step job dominates the roughly 700 cycles of all six jobs
    localparam int MAX_CYCLES   = 3000;

    logic   clk = 1'b0;
    logic   rst;
    logic   start;
    logic   step_valid;
    count_t job_len;
    feat_t  feat      [ROWS];
    wgt_t   wgt       [COLS];
    logic   res_valid;
    acc_t   res       [COLS];

    // operand matrices and the expected product of the running job
    feat_t  a_mat     [ROWS][MAX_K];
    wgt_t   b_mat     [MAX_K][COLS];
    acc_t   exp_mat   [ROWS][COLS];

    logic [31:0] lcg_state;
    int          err_count  = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          cycle_count;

    always #20 clk = ~clk;

    systolic_array DUT (
        .clk_i        (clk),
        .rst_i        (rst),
        .start_i      (start),
        .step_valid_i (step_valid),
        .len_i        (job_len),
        .feat_i       (feat),
        .wgt_i        (wgt),
        .res_valid_o  (res_valid),
        .res_o        (res)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // A zero-extended, B sign-extended, summed over the job's steps
    function automatic acc_t ref_dot(input int r, input int c, input int len);
        int sum;
        sum = 0;
        for (int k = 0; k < len; k++) begin
            sum += int'(a_mat[r][k]) * int'(b_mat[k][c]);
        end
        return acc_t'(sum);
    endfunction

    task automatic check_acc(input string name, input acc_t expected, input acc_t actual);
        if (actual !== expected) begin
            $display("** Error at %t: %s expected %0d, got %0d", $time, name, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_valid(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error at %t: %s expected %b, got %b", $time, name, expected, actual);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        int errs;
        errs = err_count - errs_before;
        if (errs == 0) begin
            pass_count++;
            $display("[%t] %s ok", $time, name);
        end else begin
            fail_count++;
            $display("[%t] %s: %0d errors", $time, name, errs);
        end
    endtask

    `include "systolic_tests.svh"

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped after %0d cycles without finishing", MAX_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        lcg_state  = 32'h3bdd;
        rst        = 1'b1;
        start      = 1'b0;
        step_valid = 1'b0;
        job_len    = '0;
        for (int r = 0; r < ROWS; r++) begin
            feat[r] = '0;
        end
        for (int c = 0; c < COLS; c++) begin
            wgt[c] = '0;
        end

        quiet_after_reset();
        identity_weights();
        signed_extremes();
        gapped_random_job();
        back_to_back_jobs();
        single_step_job();

        $display("tests: %0d ok, %0d with errors, %0d check errors in total",
                 pass_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== hdl/systolic_array.sv ====
`timescale 1ns/10ps

module systolic_array (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 start_i,
    input  logic                 step_valid_i,
    input  systolic_pkg::count_t len_i,
    input  systolic_pkg::feat_t  feat_i      [systolic_pkg::ROWS],
    input  systolic_pkg::wgt_t   wgt_i       [systolic_pkg::COLS],
    output logic                 res_valid_o,
    output systolic_pkg::acc_t   res_o       [systolic_pkg::COLS]
);

    import systolic_pkg::*;

    // skewed operand wavefront
    logic   skew_feat_valid [ROWS];
    feat_t  skew_feat       [ROWS];
    logic   skew_wgt_valid  [COLS];
    wgt_t   skew_wgt        [COLS];

    // element outputs indexed [row][col]
    logic   pe_start        [ROWS][COLS];
    count_t pe_len          [ROWS][COLS];
    logic   pe_feat_valid   [ROWS][COLS];
    feat_t  pe_feat         [ROWS][COLS];
    logic   pe_wgt_valid    [ROWS][COLS];
    wgt_t   pe_wgt          [ROWS][COLS];
    logic   pe_up_valid     [ROWS][COLS];
    acc_t   pe_up           [ROWS][COLS];

    operand_skew u_skew (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .step_valid_i (step_valid_i),
        .feat_i       (feat_i),
        .wgt_i        (wgt_i),
        .feat_valid_o (skew_feat_valid),
        .feat_o       (skew_feat),
        .wgt_valid_o  (skew_wgt_valid),
        .wgt_o        (skew_wgt)
    );

    for (genvar r = 0; r < ROWS; r++) begin : g_row
        for (genvar c = 0; c < COLS; c++) begin : g_col
            logic   start_in;
            count_t len_in;
            logic   feat_valid_in;
            feat_t  feat_in;
            logic   wgt_valid_in;
            wgt_t   wgt_in;
            logic   up_valid_in;
            acc_t   up_in;

            // start and length go down column 0, then right along the row
            if (r == 0 && c == 0) begin : g_start_origin
                assign start_in = start_i;
                assign len_in   = len_i;
            end else if (c == 0) begin : g_start_down
                assign start_in = pe_start[r-1][0];
                assign len_in   = pe_len[r-1][0];
            end else begin : g_start_right
                assign start_in = pe_start[r][c-1];
                assign len_in   = pe_len[r][c-1];
            end

            if (c == 0) begin : g_feat_edge
                assign feat_valid_in = skew_feat_valid[r];
                assign feat_in       = skew_feat[r];
            end else begin : g_feat_hop
                assign feat_valid_in = pe_feat_valid[r][c-1];
                assign feat_in       = pe_feat[r][c-1];
            end

            if (r == 0) begin : g_wgt_edge
                assign wgt_valid_in = skew_wgt_valid[c];
                assign wgt_in       = skew_wgt[c];
            end else begin : g_wgt_hop
                assign wgt_valid_in = pe_wgt_valid[r-1][c];
                assign wgt_in       = pe_wgt[r-1][c];
            end

            if (r == ROWS - 1) begin : g_up_none
                assign up_valid_in = 1'b0;   // nothing below the bottom row
                assign up_in       = '0;
            end else begin : g_up_hop
                assign up_valid_in = pe_up_valid[r+1][c];
                assign up_in       = pe_up[r+1][c];
            end

            mac_pe u_pe (
                .clk_i        (clk_i),
                .rst_i        (rst_i),
                .start_i      (start_in),
                .len_i        (len_in),
                .start_o      (pe_start[r][c]),
                .len_o        (pe_len[r][c]),
                .feat_valid_i (feat_valid_in),
                .feat_i       (feat_in),
                .feat_valid_o (pe_feat_valid[r][c]),
                .feat_o       (pe_feat[r][c]),
                .wgt_valid_i  (wgt_valid_in),
                .wgt_i        (wgt_in),
                .wgt_valid_o  (pe_wgt_valid[r][c]),
                .wgt_o        (pe_wgt[r][c]),
                .up_valid_i   (up_valid_in),
                .up_i         (up_in),
                .up_valid_o   (pe_up_valid[r][c]),
                .up_o         (pe_up[r][c])
            );
        end
    end

    // top row results leave one column per cycle apart
    result_deskew u_deskew (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .col_valid_i (pe_up_valid[0]),
        .col_i       (pe_up[0]),
        .res_valid_o (res_valid_o),
        .res_o       (res_o)
    );

endmodule

// ==== hdl/result_deskew.sv ====
`timescale 1ns/10ps

module result_deskew (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               col_valid_i [systolic_pkg::COLS],
    input  systolic_pkg::acc_t col_i       [systolic_pkg::COLS],
    output logic               res_valid_o,
    output systolic_pkg::acc_t res_o       [systolic_pkg::COLS]
);

    import systolic_pkg::*;

    logic [COLS-1:0] aligned_valid;

    // column c waits COLS-1-c cycles, the last column none
    for (genvar c = 0; c < COLS; c++) begin : g_col
        if (c == COLS - 1) begin : g_pass
            assign aligned_valid[c] = col_valid_i[c];
            assign res_o[c]         = col_i[c];
        end else begin : g_dly
            logic v_sr [COLS-1-c];
            acc_t d_sr [COLS-1-c];

            always_ff @(posedge clk_i) begin
                if (rst_i) begin
                    v_sr <= '{default: 1'b0};
                end else begin
                    v_sr[0] <= col_valid_i[c];
                    for (int i = 1; i < COLS - 1 - c; i++) begin
                        v_sr[i] <= v_sr[i-1];
                    end
                end
            end

            always_ff @(posedge clk_i) begin
                d_sr[0] <= col_i[c];
                for (int i = 1; i < COLS - 1 - c; i++) begin
                    d_sr[i] <= d_sr[i-1];
                end
            end

            assign aligned_valid[c] = v_sr[COLS-2-c];
            assign res_o[c]         = d_sr[COLS-2-c];
        end
    end

    assign res_valid_o = aligned_valid[0];

    // every column of a row lands in the same cycle
    a_row_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        (aligned_valid == '0) || (aligned_valid == '1))
        else $error("result columns out of step: %b", aligned_valid);

endmodule

// ==== hdl/mac_pe.sv ====
`timescale 1ns/10ps

module mac_pe (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 start_i,
    input  systolic_pkg::count_t len_i,
    output logic                 start_o,
    output systolic_pkg::count_t len_o,
    input  logic                 feat_valid_i,
    input  systolic_pkg::feat_t  feat_i,
    output logic                 feat_valid_o,
    output systolic_pkg::feat_t  feat_o,
    input  logic                 wgt_valid_i,
    input  systolic_pkg::wgt_t   wgt_i,
    output logic                 wgt_valid_o,
    output systolic_pkg::wgt_t   wgt_o,
    input  logic                 up_valid_i,
    input  systolic_pkg::acc_t   up_i,
    output logic                 up_valid_o,
    output systolic_pkg::acc_t   up_o
);

    import systolic_pkg::*;

    pe_state_e state_r;
    count_t    remain_r;     // steps still expected
    acc_t      acc_r;
    acc_t      prod;
    acc_t      acc_next;
    logic      start_take;
    logic      step_fire;
    logic      last_step;

    // feature zero-extended, weight sign-extended, then 32-bit multiply
    assign prod       = $signed({1'b0, feat_i}) * wgt_i;
    assign acc_next   = acc_r + prod;
    assign start_take = start_i && (state_r != PE_ACCUM);
    assign step_fire  = (state_r == PE_ACCUM) && feat_valid_i && wgt_valid_i;
    assign last_step  = step_fire && (remain_r == count_t'(1));

    // neighbour hops, one cycle each
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            start_o      <= 1'b0;
            feat_valid_o <= 1'b0;
            wgt_valid_o  <= 1'b0;
        end else begin
            start_o      <= start_i;
            feat_valid_o <= feat_valid_i;
            wgt_valid_o  <= wgt_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        len_o  <= len_i;
        feat_o <= feat_i;
        wgt_o  <= wgt_i;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_r  <= PE_IDLE;
            remain_r <= '0;
        end else begin
            case (state_r)
                PE_IDLE: begin
                    if (start_take) begin
                        state_r  <= PE_ACCUM;
                        remain_r <= len_i;
                    end
                end
                PE_ACCUM: begin
                    if (step_fire) begin
                        remain_r <= remain_r - count_t'(1);
                        if (last_step) begin
                            state_r <= PE_DONE;
                        end
                    end
                end
                PE_DONE: begin
                    if (start_take) begin   // a start may follow right away
                        state_r  <= PE_ACCUM;
                        remain_r <= len_i;
                    end else begin
                        state_r  <= PE_IDLE;
                    end
                end
                default: begin
                    state_r <= PE_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_take) begin
            acc_r <= '0;
        end else if (step_fire) begin
            acc_r <= acc_next;
        end
    end

    // upward chain takes the own sum or the one from below
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            up_valid_o <= 1'b0;
        end else begin
            up_valid_o <= last_step || up_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (last_step) begin
            up_o <= acc_next;   // final step folded in
        end else if (up_valid_i) begin
            up_o <= up_i;
        end
    end

    // skew stage and hops keep both operand lanes in step
    a_lanes_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        feat_valid_i == wgt_valid_i)
        else $error("feature and weight valids differ");

    // jobs must not overlap inside one element
    a_no_restart: assert property (@(posedge clk_i) disable iff (rst_i)
        start_i |-> state_r != PE_ACCUM)
        else $error("start while accumulating");

    // rows below finish later, so the upward slot is free
    a_up_no_clash: assert property (@(posedge clk_i) disable iff (rst_i)
        !(last_step && up_valid_i))
        else $error("own and forwarded result collide");

endmodule

// ==== hdl/operand_skew.sv ====
`timescale 1ns/10ps

module operand_skew (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                step_valid_i,
    input  systolic_pkg::feat_t feat_i       [systolic_pkg::ROWS],
    input  systolic_pkg::wgt_t  wgt_i        [systolic_pkg::COLS],
    output logic                feat_valid_o [systolic_pkg::ROWS],
    output systolic_pkg::feat_t feat_o       [systolic_pkg::ROWS],
    output logic                wgt_valid_o  [systolic_pkg::COLS],
    output systolic_pkg::wgt_t  wgt_o        [systolic_pkg::COLS]
);

    import systolic_pkg::*;

    // feature row r waits r cycles
    for (genvar r = 0; r < ROWS; r++) begin : g_feat
        if (r == 0) begin : g_pass
            assign feat_valid_o[r] = step_valid_i;
            assign feat_o[r]       = feat_i[r];
        end else begin : g_dly
            logic  v_sr [r];
            feat_t d_sr [r];

            always_ff @(posedge clk_i) begin
                if (rst_i) begin
                    v_sr <= '{default: 1'b0};
                end else begin
                    v_sr[0] <= step_valid_i;
                    for (int i = 1; i < r; i++) begin
                        v_sr[i] <= v_sr[i-1];
                    end
                end
            end

            always_ff @(posedge clk_i) begin
                d_sr[0] <= feat_i[r];
                for (int i = 1; i < r; i++) begin
                    d_sr[i] <= d_sr[i-1];
                end
            end

            assign feat_valid_o[r] = v_sr[r-1];
            assign feat_o[r]       = d_sr[r-1];
        end
    end

    // weight column c waits c cycles
    for (genvar c = 0; c < COLS; c++) begin : g_wgt
        if (c == 0) begin : g_pass
            assign wgt_valid_o[c] = step_valid_i;
            assign wgt_o[c]       = wgt_i[c];
        end else begin : g_dly
            logic v_sr [c];
            wgt_t d_sr [c];

            always_ff @(posedge clk_i) begin
                if (rst_i) begin
                    v_sr <= '{default: 1'b0};
                end else begin
                    v_sr[0] <= step_valid_i;
                    for (int i = 1; i < c; i++) begin
                        v_sr[i] <= v_sr[i-1];
                    end
                end
            end

            always_ff @(posedge clk_i) begin
                d_sr[0] <= wgt_i[c];
                for (int i = 1; i < c; i++) begin
                    d_sr[i] <= d_sr[i-1];
                end
            end

            assign wgt_valid_o[c] = v_sr[c-1];
            assign wgt_o[c]       = d_sr[c-1];
        end
    end

endmodule

// ==== hdl/systolic_pkg.sv ====
package systolic_pkg;

    // grid size
    localparam int ROWS   = 4;    // element rows, feature lanes
    localparam int COLS   = 4;    // element columns, weight and result lanes

    // datapath widths
    localparam int FEAT_W = 8;
    localparam int WGT_W  = 8;
    localparam int ACC_W  = 32;   // holds 255 * 255 * -128 with room to spare
    localparam int CNT_W  = 8;    // job length 1..255

    typedef logic        [FEAT_W-1:0] feat_t;    // unsigned feature
    typedef logic signed [WGT_W-1:0]  wgt_t;     // signed weight
    typedef logic signed [ACC_W-1:0]  acc_t;     // dot product result
    typedef logic        [CNT_W-1:0]  count_t;   // steps in one job

    // element FSM
    typedef enum logic [1:0] {
        PE_IDLE  = 2'd0,   // waiting for a job start
        PE_ACCUM = 2'd1,   // summing operand pairs
        PE_DONE  = 2'd2    // result just pushed upward
    } pe_state_e;

endpackage
